//--- source/chart_player_pkg.sv
package chart_player_pkg;

    // Keys per octave, C to B
    localparam int NUM_KEYS = 7;

    // Bit 8 octave down, bit 7 octave up, bits 6..0 one-hot keys with C at bit 0
    typedef logic [NUM_KEYS+1:0] note_t;
    typedef logic [7:0]          note_idx_t;
    typedef logic [13:0]         score_t;
    typedef logic [7:0]          led_t;
    typedef logic [1:0]          countdown_t;
    typedef logic [1:0]          arrow_t;

    // Wide enough for every tick period below
    typedef logic [3:0]          cycle_cnt_t;

    // Arrow key codes
    localparam arrow_t ARROW_NONE  = 2'd0;
    localparam arrow_t ARROW_LEFT  = 2'd1;
    localparam arrow_t ARROW_RIGHT = 2'd2;
    localparam arrow_t ARROW_UP    = 2'd3;
    // No free code left in two bits, so down reads the same as none
    localparam arrow_t ARROW_DOWN  = 2'd0;

    // Tick periods in prog_clk cycles
    localparam int COUNT_STEP_CYCLES = 8;
    localparam int NOTE_CYCLES       = 12;
    localparam int SCAN_CYCLES       = 4;

    // Points per timing window
    localparam score_t PTS_EXACT = 14'd5;
    localparam score_t PTS_LATE1 = 14'd3;
    localparam score_t PTS_LATE2 = 14'd2;

    typedef enum logic [1:0] {
        COUNTING,
        PLAYING,
        FINISHED
    } play_state_t;

endpackage

//--- source/play_status_if.sv
interface play_status_if;

    // High for the whole PLAYING state
    logic                        play_en;
    // One-cycle step strobe
    logic                        note_tick;
    chart_player_pkg::note_idx_t note_index;
    logic                        finished;

    modport ctrl (
        output play_en,
        output note_tick,
        output note_index,
        output finished
    );

    modport user (
        input play_en,
        input note_tick,
        input note_index,
        input finished
    );

endinterface

//--- source/play_control.sv
module play_control (
    input  logic                         prog_clk,
    input  logic                         rst,
    input  chart_player_pkg::arrow_t     arrow_keys,
    input  logic [7:0]                   chart_id,
    input  chart_player_pkg::note_idx_t  note_total,
    input  chart_player_pkg::score_t     score,
    play_status_if.ctrl                  status,
    output chart_player_pkg::countdown_t countdown,
    output logic                         save_strobe,
    output logic [7:0]                   save_chart_id,
    output chart_player_pkg::score_t     save_score,
    output logic                         exit_strobe
);

    chart_player_pkg::play_state_t state;
    chart_player_pkg::cycle_cnt_t  step_cnt;
    chart_player_pkg::cycle_cnt_t  note_cnt;
    chart_player_pkg::note_idx_t   note_index;
    chart_player_pkg::arrow_t      prev_arrow;
    logic                          step_done;
    logic                          note_tick;
    logic                          chart_done;
    logic                          keys_live;
    logic                          save_press;
    logic                          exit_press;

    assign step_done = step_cnt ==
        chart_player_pkg::cycle_cnt_t'(chart_player_pkg::COUNT_STEP_CYCLES - 1);

    // Endless chart when note_total is zero
    assign chart_done = (note_total != '0) && (note_index == note_total);

    // No step once the last note is reached
    assign note_tick = (state == chart_player_pkg::PLAYING) && !chart_done &&
        (note_cnt == chart_player_pkg::cycle_cnt_t'(chart_player_pkg::NOTE_CYCLES - 1));

    // Countdown 3..0, then one more step before play starts
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            state     <= chart_player_pkg::COUNTING;
            countdown <= 2'd3;
            step_cnt  <= '0;
        end else begin
            case (state)
                chart_player_pkg::COUNTING: begin
                    if (step_done) begin
                        step_cnt <= '0;
                        if (countdown == 2'd0) begin
                            state <= chart_player_pkg::PLAYING;
                        end else begin
                            countdown <= countdown - 1'b1;
                        end
                    end else begin
                        step_cnt <= step_cnt + 1'b1;
                    end
                end
                chart_player_pkg::PLAYING: begin
                    if (chart_done) begin
                        state <= chart_player_pkg::FINISHED;
                    end
                end
                default: begin
                    // FINISHED holds until reset
                    state <= chart_player_pkg::FINISHED;
                end
            endcase
        end
    end

    // Note step counter and chart position
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            note_cnt   <= '0;
            note_index <= '0;
        end else if (state == chart_player_pkg::PLAYING) begin
            if (note_tick) begin
                note_cnt   <= '0;
                note_index <= note_index + 1'b1;
            end else if (!chart_done) begin
                note_cnt <= note_cnt + 1'b1;
            end
        end
    end

    // Arrow presses count only after the countdown
    assign keys_live  = state != chart_player_pkg::COUNTING;
    assign save_press = keys_live && (arrow_keys == chart_player_pkg::ARROW_RIGHT) &&
        (prev_arrow != chart_player_pkg::ARROW_RIGHT);
    assign exit_press = keys_live && (arrow_keys == chart_player_pkg::ARROW_LEFT) &&
        (prev_arrow != chart_player_pkg::ARROW_LEFT);

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            prev_arrow    <= chart_player_pkg::ARROW_NONE;
            save_strobe   <= 1'b0;
            exit_strobe   <= 1'b0;
            save_chart_id <= '0;
            save_score    <= '0;
        end else begin
            prev_arrow  <= arrow_keys;
            save_strobe <= save_press;
            exit_strobe <= exit_press;
            // Snapshot taken with the press
            if (save_press) begin
                save_chart_id <= chart_id;
                save_score    <= score;
            end
        end
    end

    assign status.play_en    = state == chart_player_pkg::PLAYING;
    assign status.finished   = state == chart_player_pkg::FINISHED;
    assign status.note_tick  = note_tick;
    assign status.note_index = note_index;

    a_strobes_exclusive: assert property (
        @(posedge prog_clk) disable iff (rst)
        !(save_strobe && exit_strobe)
    );

    a_index_in_chart: assert property (
        @(posedge prog_clk) disable iff (rst)
        (note_total != '0) |-> (status.note_index <= note_total)
    );

endmodule

//--- source/score_keeper.sv
module score_keeper (
    input  logic                     prog_clk,
    input  logic                     rst,
    play_status_if.user              status,
    input  chart_player_pkg::note_t  chart_note,
    input  chart_player_pkg::note_t  user_note,
    input  logic                     auto_play,
    input  logic                     free_play,
    output chart_player_pkg::score_t score,
    output chart_player_pkg::score_t max_score
);

    chart_player_pkg::cycle_cnt_t scan_cnt;
    // hist_0 is one scan old, hist_1 two
    chart_player_pkg::note_t      hist_0;
    chart_player_pkg::note_t      hist_1;
    logic                         scan_tick;
    logic                         scoring;
    logic                         keys_down;

    assign scan_tick = status.play_en &&
        (scan_cnt == chart_player_pkg::cycle_cnt_t'(chart_player_pkg::SCAN_CYCLES - 1));

    // Rests and free play never score
    assign scoring = scan_tick && !free_play &&
        (chart_note[chart_player_pkg::NUM_KEYS-1:0] != '0);

    assign keys_down = user_note[chart_player_pkg::NUM_KEYS-1:0] != '0;

    // Scan period counter, idle outside play
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            scan_cnt <= '0;
        end else if (!status.play_en || scan_tick) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            score     <= '0;
            max_score <= '0;
            hist_0    <= '0;
            hist_1    <= '0;
        end else if (scoring) begin
            max_score <= max_score + chart_player_pkg::PTS_EXACT;
            hist_0    <= user_note;
            hist_1    <= hist_0;
            if (auto_play) begin
                score <= score + chart_player_pkg::PTS_EXACT;
            end else if (keys_down) begin
                // Earliest window wins
                if (chart_note == user_note) begin
                    score <= score + chart_player_pkg::PTS_EXACT;
                end else if (chart_note == hist_0) begin
                    score <= score + chart_player_pkg::PTS_LATE1;
                end else if (chart_note == hist_1) begin
                    score <= score + chart_player_pkg::PTS_LATE2;
                end
            end
        end
    end

    a_score_bounded: assert property (
        @(posedge prog_clk) disable iff (rst)
        score <= max_score
    );

endmodule

//--- source/note_output.sv
module note_output (
    input  logic                    prog_clk,
    input  logic                    rst,
    play_status_if.user             status,
    input  chart_player_pkg::note_t chart_note,
    input  chart_player_pkg::note_t user_note,
    input  logic                    auto_play,
    output chart_player_pkg::note_t play_note,
    output chart_player_pkg::led_t  led
);

    chart_player_pkg::led_t led_next;

    // LED pattern for the current chart note
    always_comb begin
        led_next = '0;
        // Octave marker lights for up or down, not both
        led_next[0] = chart_note[chart_player_pkg::NUM_KEYS+1] ^
            chart_note[chart_player_pkg::NUM_KEYS];
        // Key C on led 7 down to key B on led 1
        if ($onehot(chart_note[chart_player_pkg::NUM_KEYS-1:0])) begin
            for (int k = 0; k < chart_player_pkg::NUM_KEYS; k++) begin
                led_next[chart_player_pkg::NUM_KEYS-k] = chart_note[k];
            end
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            play_note <= '0;
            led       <= '0;
        end else begin
            if (status.note_tick) begin
                play_note <= auto_play ? chart_note : user_note;
            end
            // LEDs freeze outside play
            if (status.play_en) begin
                led <= led_next;
            end
        end
    end

    a_led_keys_onehot0: assert property (
        @(posedge prog_clk) disable iff (rst)
        $onehot0(led[7:1])
    );

endmodule

//--- source/chart_player_top.sv
module chart_player_top (
    input  logic                                  prog_clk,
    input  logic                                  rst,
    input  logic [chart_player_pkg::NUM_KEYS-1:0] note_keys,
    input  logic                                  oct_up,
    input  logic                                  oct_down,
    input  chart_player_pkg::arrow_t              arrow_keys,
    input  logic [7:0]                            chart_id,
    input  chart_player_pkg::note_idx_t           note_total,
    input  chart_player_pkg::note_t               chart_note,
    input  logic                                  auto_play,
    input  logic                                  free_play,
    output chart_player_pkg::note_idx_t           chart_addr,
    output chart_player_pkg::countdown_t          countdown,
    output logic                                  playing,
    output logic                                  finished,
    output chart_player_pkg::note_t               play_note,
    output chart_player_pkg::led_t                led,
    output chart_player_pkg::score_t              score,
    output chart_player_pkg::score_t              max_score,
    output logic                                  save_strobe,
    output logic [7:0]                            save_chart_id,
    output chart_player_pkg::score_t              save_score,
    output logic                                  exit_strobe
);

    chart_player_pkg::note_t user_note;

    play_status_if status ();

    // Same bit layout as a chart note
    assign user_note = {oct_down, oct_up, note_keys};

    // Chart memory is addressed by the current position
    assign chart_addr = status.note_index;
    assign playing    = status.play_en;
    assign finished   = status.finished;

    play_control u_play_control (
        .prog_clk      (prog_clk),
        .rst           (rst),
        .arrow_keys    (arrow_keys),
        .chart_id      (chart_id),
        .note_total    (note_total),
        .score         (score),
        .status        (status),
        .countdown     (countdown),
        .save_strobe   (save_strobe),
        .save_chart_id (save_chart_id),
        .save_score    (save_score),
        .exit_strobe   (exit_strobe)
    );

    score_keeper u_score_keeper (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .status     (status),
        .chart_note (chart_note),
        .user_note  (user_note),
        .auto_play  (auto_play),
        .free_play  (free_play),
        .score      (score),
        .max_score  (max_score)
    );

    note_output u_note_output (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .status     (status),
        .chart_note (chart_note),
        .user_note  (user_note),
        .auto_play  (auto_play),
        .play_note  (play_note),
        .led        (led)
    );

endmodule

//--- verif/tb_chart_player.sv
module tb_chart_player;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int CHART_DEPTH  = 64;
    localparam int SEED         = 36703;
    localparam int FIXED_TOTAL  = 20;
    // Runs past the end of the chart memory so the address wraps
    localparam int ENDLESS_NOTES = 70;
    localparam int TAIL_CYCLES  = 30;
    localparam int PRESS_AT     = 8;
    localparam int HOLD         = 5;
    localparam int LEAD_CYCLES  = RESET_CYCLES + 4 * chart_player_pkg::COUNT_STEP_CYCLES;
    localparam int PHASE_CYCLES =
        LEAD_CYCLES + FIXED_TOTAL * chart_player_pkg::NOTE_CYCLES + TAIL_CYCLES + 2;
    localparam int ENDLESS_CYCLES =
        LEAD_CYCLES + ENDLESS_NOTES * chart_player_pkg::NOTE_CYCLES + TAIL_CYCLES + 2;
    localparam int TIMEOUT = (3 * PHASE_CYCLES + ENDLESS_CYCLES + 200) * CLK_PERIOD;

    logic                                  prog_clk;
    logic                                  rst;
    logic [chart_player_pkg::NUM_KEYS-1:0] note_keys;
    logic                                  oct_up;
    logic                                  oct_down;
    chart_player_pkg::arrow_t              arrow_keys;
    logic [7:0]                            chart_id;
    chart_player_pkg::note_idx_t           note_total;
    chart_player_pkg::note_t               chart_note;
    logic                                  auto_play;
    logic                                  free_play;
    chart_player_pkg::note_idx_t           chart_addr;
    chart_player_pkg::countdown_t          countdown;
    logic                                  playing;
    logic                                  finished;
    chart_player_pkg::note_t               play_note;
    chart_player_pkg::led_t                led;
    chart_player_pkg::score_t              score;
    chart_player_pkg::score_t              max_score;
    logic                                  save_strobe;
    logic [7:0]                            save_chart_id;
    chart_player_pkg::score_t              save_score;
    logic                                  exit_strobe;

    chart_player_pkg::note_t chart_mem [CHART_DEPTH];
    chart_player_pkg::note_t user_note;
    logic [31:0]             rng_state;
    int                      value_errs = 0;
    int                      other_errs = 0;
    int                      seen_saves = 0;
    int                      seen_exits = 0;
    int                      exp_presses = 0;

    // Expected state rebuilt from the timing rules
    int                           m_edges;
    int                           m_pcnt;
    chart_player_pkg::countdown_t m_cd;
    logic                         m_play;
    logic                         m_fin;
    chart_player_pkg::note_idx_t  m_idx;
    chart_player_pkg::note_t      m_pnote;
    chart_player_pkg::led_t       m_led;
    chart_player_pkg::score_t     m_score;
    chart_player_pkg::score_t     m_max;
    chart_player_pkg::note_t      m_h0;
    chart_player_pkg::note_t      m_h1;
    chart_player_pkg::arrow_t     m_prev;
    logic                         m_save;
    logic                         m_exit;
    logic [7:0]                   m_sid;
    chart_player_pkg::score_t     m_sscore;
    chart_player_pkg::note_t      cur_note;
    logic                         m_end;
    logic                         m_tick;
    logic                         m_scan;
    logic                         save_hit;
    logic                         exit_hit;

    chart_player_top u_dut (.*);

    always #(CLK_PERIOD / 2) prog_clk = ~prog_clk;

    // Combinational chart memory that wraps every 64 notes
    assign chart_note = chart_mem[chart_addr[5:0]];
    assign user_note  = {oct_down, oct_up, note_keys};

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // One key in eight is a rest
    function automatic chart_player_pkg::note_t random_note(input logic [31:0] r);
        chart_player_pkg::note_t n;
        n = '0;
        if (r[2:0] != 3'd7) begin
            n[6:0] = 7'd1 << r[2:0];
        end
        n[8:7] = r[9:8];
        return n;
    endfunction

    function automatic chart_player_pkg::led_t led_pattern(input chart_player_pkg::note_t n);
        chart_player_pkg::led_t pat;
        pat = '0;
        pat[0] = n[8] != n[7];
        if ($countones(n[6:0]) == 1) begin
            pat[7:1] = {n[0], n[1], n[2], n[3], n[4], n[5], n[6]};
        end
        return pat;
    endfunction

    function automatic chart_player_pkg::score_t hit_points(
        input chart_player_pkg::note_t chart,
        input chart_player_pkg::note_t user,
        input chart_player_pkg::note_t h0,
        input chart_player_pkg::note_t h1
    );
        if (chart == user) return chart_player_pkg::PTS_EXACT;
        if (chart == h0) return chart_player_pkg::PTS_LATE1;
        if (chart == h1) return chart_player_pkg::PTS_LATE2;
        return '0;
    endfunction

    // RIGHT held, a gap, then LEFT held
    function automatic chart_player_pkg::arrow_t arrow_for(input int t);
        if (t >= PRESS_AT && t < PRESS_AT + HOLD) return chart_player_pkg::ARROW_RIGHT;
        if (t >= PRESS_AT + 2 * HOLD && t < PRESS_AT + 3 * HOLD) begin
            return chart_player_pkg::ARROW_LEFT;
        end
        return chart_player_pkg::ARROW_NONE;
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        value_errs++;
        $display("ERR %s expected %h actual %h", name, exp, act);
    endtask

    task automatic report_fault(input string what);
        other_errs++;
        $display("%s", what);
    endtask

    assign cur_note = chart_mem[m_idx[5:0]];
    assign m_end    = (note_total != '0) && (m_idx == note_total);
    assign m_tick   = m_play && !m_end && ((m_pcnt + 1) % chart_player_pkg::NOTE_CYCLES == 0);
    assign m_scan   = m_play && ((m_pcnt + 1) % chart_player_pkg::SCAN_CYCLES == 0);
    assign save_hit = (m_play || m_fin) && (arrow_keys == chart_player_pkg::ARROW_RIGHT) &&
        (m_prev != chart_player_pkg::ARROW_RIGHT);
    assign exit_hit = (m_play || m_fin) && (arrow_keys == chart_player_pkg::ARROW_LEFT) &&
        (m_prev != chart_player_pkg::ARROW_LEFT);

    always @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            m_edges  <= 0;
            m_pcnt   <= 0;
            m_cd     <= 2'd3;
            m_play   <= 1'b0;
            m_fin    <= 1'b0;
            m_idx    <= '0;
            m_pnote  <= '0;
            m_led    <= '0;
            m_score  <= '0;
            m_max    <= '0;
            m_h0     <= '0;
            m_h1     <= '0;
            m_prev   <= chart_player_pkg::ARROW_NONE;
            m_save   <= 1'b0;
            m_exit   <= 1'b0;
            m_sid    <= '0;
            m_sscore <= '0;
        end else begin
            m_edges <= m_edges + 1;
            // One digit per step from 3 down to 0 and play after a fourth step
            if (m_edges + 1 >= 3 * chart_player_pkg::COUNT_STEP_CYCLES) begin
                m_cd <= '0;
            end else begin
                m_cd <= chart_player_pkg::countdown_t'(
                    3 - (m_edges + 1) / chart_player_pkg::COUNT_STEP_CYCLES);
            end
            if (!m_play && !m_fin && m_edges + 1 == 4 * chart_player_pkg::COUNT_STEP_CYCLES) begin
                m_play <= 1'b1;
            end
            if (m_play && m_end) begin
                m_play <= 1'b0;
                m_fin  <= 1'b1;
            end
            if (m_play) begin
                m_pcnt <= m_pcnt + 1;
                m_led  <= led_pattern(cur_note);
            end
            if (m_tick) begin
                m_idx   <= m_idx + 1'b1;
                m_pnote <= auto_play ? cur_note : user_note;
            end
            if (m_scan && !free_play && cur_note[6:0] != '0) begin
                m_max <= m_max + chart_player_pkg::PTS_EXACT;
                m_h0  <= user_note;
                m_h1  <= m_h0;
                if (auto_play) begin
                    m_score <= m_score + chart_player_pkg::PTS_EXACT;
                end else if (user_note[6:0] != '0) begin
                    m_score <= m_score + hit_points(cur_note, user_note, m_h0, m_h1);
                end
            end
            m_prev <= arrow_keys;
            m_save <= save_hit;
            m_exit <= exit_hit;
            if (save_hit) begin
                m_sid    <= chart_id;
                m_sscore <= m_score;
            end
        end
    end

    always @(posedge prog_clk) begin
        if (!rst && save_strobe) seen_saves <= seen_saves + 1;
        if (!rst && exit_strobe) seen_exits <= seen_exits + 1;
    end

    a_countdown: assert property (@(posedge prog_clk) disable iff (rst) countdown == m_cd)
        else report_value("countdown", 32'($sampled(m_cd)), 32'($sampled(countdown)));
    a_playing: assert property (@(posedge prog_clk) disable iff (rst) playing == m_play)
        else report_value("playing", 32'($sampled(m_play)), 32'($sampled(playing)));
    a_finished: assert property (@(posedge prog_clk) disable iff (rst) finished == m_fin)
        else report_value("finished", 32'($sampled(m_fin)), 32'($sampled(finished)));
    a_chart_addr: assert property (@(posedge prog_clk) disable iff (rst) chart_addr == m_idx)
        else report_value("chart_addr", 32'($sampled(m_idx)), 32'($sampled(chart_addr)));
    a_play_note: assert property (@(posedge prog_clk) disable iff (rst) play_note == m_pnote)
        else report_value("play_note", 32'($sampled(m_pnote)), 32'($sampled(play_note)));
    a_led: assert property (@(posedge prog_clk) disable iff (rst) led == m_led)
        else report_value("led", 32'($sampled(m_led)), 32'($sampled(led)));
    a_score: assert property (@(posedge prog_clk) disable iff (rst) score == m_score)
        else report_value("score", 32'($sampled(m_score)), 32'($sampled(score)));
    a_max_score: assert property (@(posedge prog_clk) disable iff (rst) max_score == m_max)
        else report_value("max_score", 32'($sampled(m_max)), 32'($sampled(max_score)));
    a_auto_full: assert property (@(posedge prog_clk) disable iff (rst)
        auto_play |-> score == m_max)
        else report_value("score", 32'($sampled(m_max)), 32'($sampled(score)));
    a_save: assert property (@(posedge prog_clk) disable iff (rst) save_strobe == m_save)
        else report_value("save_strobe", 32'($sampled(m_save)), 32'($sampled(save_strobe)));
    a_exit: assert property (@(posedge prog_clk) disable iff (rst) exit_strobe == m_exit)
        else report_value("exit_strobe", 32'($sampled(m_exit)), 32'($sampled(exit_strobe)));
    a_save_id: assert property (@(posedge prog_clk) disable iff (rst)
        save_strobe |-> save_chart_id == m_sid)
        else report_value("save_chart_id", 32'($sampled(m_sid)), 32'($sampled(save_chart_id)));
    a_save_score: assert property (@(posedge prog_clk) disable iff (rst)
        save_strobe |-> save_score == m_sscore)
        else report_value("save_score", 32'($sampled(m_sscore)), 32'($sampled(save_score)));
    a_no_overlap: assert property (@(posedge prog_clk) disable iff (rst)
        !(save_strobe && exit_strobe))
        else report_fault("Save and exit strobes were high in the same cycle");

    task automatic next_slot;
        @(posedge prog_clk);
        #2;
    endtask

    // Often the chart note itself so every timing window gets hit
    task automatic drive_keys;
        chart_player_pkg::note_t n;
        rng_state = xorshift(rng_state);
        case (rng_state[1:0])
            2'd0: n = cur_note;
            2'd1: n = '0;
            default: n = random_note(rng_state >> 2);
        endcase
        {oct_down, oct_up, note_keys} = n;
    endtask

    task automatic run_phase(input logic auto_en, input logic free_en,
                             input chart_player_pkg::note_idx_t total);
        int t;
        auto_play  = auto_en;
        free_play  = free_en;
        note_total = total;
        rng_state  = xorshift(rng_state);
        chart_id   = rng_state[7:0];
        arrow_keys = chart_player_pkg::ARROW_NONE;
        rst = 1'b1;
        repeat (RESET_CYCLES) next_slot();
        rst = 1'b0;
        t = 0;
        while (!finished &&
               !(total == '0 && chart_addr == chart_player_pkg::note_idx_t'(ENDLESS_NOTES))) begin
            next_slot();
            if (playing) t++;
            drive_keys();
            arrow_keys = arrow_for(t);
        end
        // Second pair of presses after the end or while still playing
        for (t = 0; t < TAIL_CYCLES; t++) begin
            next_slot();
            drive_keys();
            arrow_keys = arrow_for(t);
        end
        exp_presses += 2;
    endtask

    initial begin
        prog_clk   = 1'b0;
        rst        = 1'b1;
        note_keys  = '0;
        oct_up     = 1'b0;
        oct_down   = 1'b0;
        arrow_keys = chart_player_pkg::ARROW_NONE;
        chart_id   = '0;
        note_total = '0;
        auto_play  = 1'b0;
        free_play  = 1'b0;
        rng_state  = SEED;
        for (int i = 0; i < CHART_DEPTH; i++) begin
            rng_state    = xorshift(rng_state);
            chart_mem[i] = random_note(rng_state);
        end
        run_phase(1'b1, 1'b0, chart_player_pkg::note_idx_t'(FIXED_TOTAL));
        run_phase(1'b0, 1'b0, chart_player_pkg::note_idx_t'(FIXED_TOTAL));
        run_phase(1'b0, 1'b1, chart_player_pkg::note_idx_t'(FIXED_TOTAL));
        run_phase(1'b0, 1'b0, '0);
        if (seen_saves != exp_presses) report_fault("Wrong number of save strobes seen");
        if (seen_exits != exp_presses) report_fault("Wrong number of exit strobes seen");
        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog sized from the four phase lengths
    initial begin
        #(TIMEOUT);
        $display("Run timed out before all phases completed");
        $display("Verification failed");
        $finish;
    end

endmodule

//--- filelist.f
source/chart_player_pkg.sv
source/play_status_if.sv
source/play_control.sv
source/score_keeper.sv
source/note_output.sv
source/chart_player_top.sv
verif/tb_chart_player.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_chart_player -f filelist.f \
    -o sim_chart_player > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_chart_player > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0
